// File: Bender.yml
package:
  name: frame_writer

sources:
  - files:
      - hw/fb_pkg.sv
      - hw/burst_if.sv
      - hw/pixel_packer.sv
      - hw/beat_fifo.sv
      - hw/frame_writer_ctrl.sv
      - hw/aw_channel.sv
      - hw/w_channel.sv
      - hw/frame_writer_top.sv
  - target: simulation
    files:
      - dv/frame_checker.sv
      - dv/tb_frame_writer.sv

// File: dv/frame_checker.sv
/* Watches the frame writer ports, packs the pixel input on its own and
   compares addresses, beats, responses and pulses. Counts errors for the top. */
module frame_checker #(
	parameter int burst_len = 4
) (
	input logic clk,
	input logic rstn,
	input logic soft_resetn,
	input logic resetting,
	input logic [31:0] base_addr,
	input integer frame_bursts,
	input logic pixel_valid,
	input logic [7:0] pixel,
	input logic pixel_sof,
	input logic frame_pulse,
	input logic bresp_error,
	input logic overflow,
	input logic [0:0] awid,
	input logic [31:0] awaddr,
	input logic [7:0] awlen,
	input logic [2:0] awsize,
	input logic [1:0] awburst,
	input logic awlock,
	input logic [3:0] awcache,
	input logic [2:0] awprot,
	input logic [3:0] awqos,
	input logic awvalid,
	input logic awready,
	input logic [31:0] wdata,
	input logic [3:0] wstrb,
	input logic wlast,
	input logic wvalid,
	input logic wready,
	input logic [1:0] bresp,
	input logic bvalid,
	input logic bready
);
	timeunit 1ns;
	timeprecision 1ps;

	integer mismatches = 0;
	integer failures = 0;

	logic [31:0] exp_q [$];
	logic [31:0] aw_q [$];
	logic [31:0] wq [$];
	logic [31:0] shadow [logic [31:0]];
	logic [31:0] pack;
	logic [31:0] exp_addr;
	logic b_prev, slverr_seen, sr_pending;
	int lane, aw_idx, beat_cnt, wr_beat, bursts_since, pulses, open_bursts;

	task automatic fail(input string what);
		$display("%t: %s", $time, what);
		failures++;
	endtask

	task automatic check_field(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			$display("mismatch %s: got %h expected %h", name, got, expected);
			mismatches++;
		end
	endtask

	task automatic check_word(input logic [31:0] addr, input logic [31:0] expected);
		if (!shadow.exists(addr))
			fail($sformatf("no write reached address %h", addr));
		else if (shadow[addr] !== expected) begin
			$display("mismatch mem[%h]: got %h expected %h", addr, shadow[addr], expected);
			mismatches++;
		end
	endtask

	task automatic final_checks(input int expected_pulses);
		if (pulses != expected_pulses) begin
			$display("mismatch frame_pulse count: got %h expected %h", pulses, expected_pulses);
			mismatches++;
		end
		if (bresp_error !== 1'b1)
			fail("bresp_error is not set after the error response");
		if (aw_q.size() != 0 || wq.size() != 0)
			fail("writes left without a matching address or data");
	endtask

	always @(negedge clk) begin
		if (!rstn) begin
			exp_q.delete();
			aw_q.delete();
			wq.delete();
			lane = 0;
			aw_idx = 0;
			beat_cnt = 0;
			wr_beat = 0;
			bursts_since = 0;
			pulses = 0;
			open_bursts = 0;
			b_prev = 1'b0;
			slverr_seen = 1'b0;
			sr_pending = 1'b0;
		end else begin
			if (overflow)
				fail("FIFO overflow flag is set");
			if (bresp_error && !slverr_seen)
				fail("bresp_error set without an error response");

			// Expected beats from the pixel stream
			if (resetting) begin
				exp_q.delete();
				lane = 0;
				aw_idx = 0;
				bursts_since = 0;
			end else if (pixel_valid) begin
				if (pixel_sof)
					lane = 0;
				pack[8 * lane +: 8] = pixel;
				if (lane == 3)
					exp_q.push_back(pack);
				lane = (lane + 1) % 4;
			end

			if (!soft_resetn && (open_bursts > 0 || awvalid))
				sr_pending = 1'b1;
			if (sr_pending && !resetting)
				fail("resetting dropped before the open burst got its response");

			if (awvalid && awready) begin
				exp_addr = base_addr + 32'(aw_idx * burst_len * 4);
				if (awaddr !== exp_addr) begin
					$display("mismatch M_AXI_AWADDR: got %h expected %h", awaddr, exp_addr);
					mismatches++;
				end
				// Single ID, INCR bursts of full 4-byte beats
				check_field("M_AXI_AWID", 32'(awid), 32'd0);
				check_field("M_AXI_AWLEN", 32'(awlen), 32'(burst_len - 1));
				check_field("M_AXI_AWSIZE", 32'(awsize), 32'd2);
				check_field("M_AXI_AWBURST", 32'(awburst), 32'd1);
				check_field("M_AXI_AWLOCK", 32'(awlock), 32'd0);
				check_field("M_AXI_AWCACHE", 32'(awcache), 32'h2);
				check_field("M_AXI_AWPROT", 32'(awprot), 32'd0);
				check_field("M_AXI_AWQOS", 32'(awqos), 32'd0);
				aw_q.push_back(awaddr);
				aw_idx++;
				open_bursts++;
			end

			if (wvalid && wready) begin
				beat_cnt++;
				if (wlast !== (beat_cnt == burst_len)) begin
					$display("mismatch M_AXI_WLAST: got %h expected %h", wlast,
						beat_cnt == burst_len);
					mismatches++;
				end
				check_field("M_AXI_WSTRB", 32'(wstrb), 32'hf);
				if (wlast || beat_cnt == burst_len)
					beat_cnt = 0;
				if (!resetting) begin
					if (exp_q.size() == 0)
						fail("data beat written with no pixels behind it");
					else if (wdata !== exp_q[0]) begin
						$display("mismatch M_AXI_WDATA: got %h expected %h", wdata, exp_q[0]);
						mismatches++;
					end
					if (exp_q.size() != 0)
						void'(exp_q.pop_front());
				end
				wq.push_back(wdata);
			end

			// Data may run ahead of its address
			while (aw_q.size() != 0 && wq.size() != 0) begin
				shadow[aw_q[0] + 32'(4 * wr_beat)] = wq.pop_front();
				wr_beat++;
				if (wr_beat == burst_len) begin
					void'(aw_q.pop_front());
					wr_beat = 0;
				end
			end

			if (frame_pulse) begin
				pulses++;
				if (!b_prev)
					fail("frame_pulse without a response in the cycle before");
				if (bursts_since != frame_bursts) begin
					$display("mismatch bursts per frame: got %h expected %h",
						bursts_since, frame_bursts);
					mismatches++;
				end
				bursts_since = 0;
				aw_idx = 0;
			end

			if (bvalid) begin
				check_field("M_AXI_BREADY", 32'(bready), 32'd1);
				open_bursts--;
				sr_pending = 1'b0;
				if (!resetting)
					bursts_since++;
				if (bresp[1])
					slverr_seen = 1'b1;
			end
			b_prev = bvalid;
		end
	end

endmodule

// File: dv/frame_testdata.hex
// Words 0-5: width, height, base frame 0, base frames 1-2, soft reset pixel, SLVERR burst
// Words 6 on: pixel words, four pixels each with lane 0 in the low byte
00000010
00000002
00001000
00002000
00000008
00000001
// Frame 0, 32 pixels
03020100
07060504
0b0a0908
0f0e0d0c
13121110
17161514
1b1a1918
1f1e1d1c
// Frame 1, 16 pixels, cut by soft reset
a3a2a1a0
a7a6a5a4
abaaa9a8
afaeadac
// Frame 2, 32 pixels
c0d1e2f3
11223344
55667788
99aabbcc
ddeeff00
0f1e2d3c
4b5a6978
8796a5b4

// File: dv/tb_frame_writer.sv
/* Testbench top for the frame writer. Reads frame setup and pixels from the
   testdata file, drives the pixel port and models an AXI slave with stalls. */
module tb_frame_writer;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int burst_len = 4;
	localparam int addr_width = 32;
	localparam int data_width = 32;
	localparam int img_wbits = 12;
	localparam int img_hbits = 12;
	localparam int wait_limit = 2000;

	// Word map of the testdata file
	localparam int td_width = 0;
	localparam int td_height = 1;
	localparam int td_base0 = 2;
	localparam int td_base1 = 3;
	localparam int td_reset_px = 4;
	localparam int td_err_burst = 5;
	localparam int td_frame0 = 6;
	localparam int td_frame1 = 14;
	localparam int td_frame2 = 18;

	logic [31:0] td [0:25];
	integer seed = 10;
	integer timeouts = 0;
	integer aw_cnt, wl_cnt, b_cnt;
	integer frame_bursts;
	bit aw_hs, wl_hs, b_hs;

	logic M_AXI_ACLK, M_AXI_ARESETN, soft_resetn, resetting;
	logic [img_wbits-1:0] img_width;
	logic [img_hbits-1:0] img_height;
	logic [addr_width-1:0] base_addr;
	logic pixel_valid, pixel_sof;
	logic [7:0] pixel;
	logic frame_pulse, bresp_error, overflow;
	logic [0:0] M_AXI_AWID, M_AXI_BID;
	logic [addr_width-1:0] M_AXI_AWADDR;
	logic [7:0] M_AXI_AWLEN;
	logic [2:0] M_AXI_AWSIZE, M_AXI_AWPROT;
	logic [1:0] M_AXI_AWBURST, M_AXI_BRESP;
	logic [3:0] M_AXI_AWCACHE, M_AXI_AWQOS, M_AXI_WSTRB;
	logic M_AXI_AWLOCK, M_AXI_AWVALID, M_AXI_AWREADY;
	logic [data_width-1:0] M_AXI_WDATA;
	logic M_AXI_WLAST, M_AXI_WVALID, M_AXI_WREADY;
	logic M_AXI_BVALID, M_AXI_BREADY;

	always #5 M_AXI_ACLK = ~M_AXI_ACLK;

	frame_writer_top #(
		.burst_len(burst_len), .addr_width(addr_width), .data_width(data_width),
		.img_wbits(img_wbits), .img_hbits(img_hbits), .fifo_depth(32)
	) i_dut (.*);

	frame_checker #(.burst_len(burst_len)) i_checker (
		.clk(M_AXI_ACLK), .rstn(M_AXI_ARESETN), .soft_resetn(soft_resetn),
		.resetting(resetting), .base_addr(base_addr), .frame_bursts(frame_bursts),
		.pixel_valid(pixel_valid), .pixel(pixel), .pixel_sof(pixel_sof),
		.frame_pulse(frame_pulse), .bresp_error(bresp_error), .overflow(overflow),
		.awid(M_AXI_AWID), .awaddr(M_AXI_AWADDR), .awlen(M_AXI_AWLEN),
		.awsize(M_AXI_AWSIZE), .awburst(M_AXI_AWBURST), .awlock(M_AXI_AWLOCK),
		.awcache(M_AXI_AWCACHE), .awprot(M_AXI_AWPROT), .awqos(M_AXI_AWQOS),
		.awvalid(M_AXI_AWVALID), .awready(M_AXI_AWREADY),
		.wdata(M_AXI_WDATA), .wstrb(M_AXI_WSTRB), .wlast(M_AXI_WLAST),
		.wvalid(M_AXI_WVALID), .wready(M_AXI_WREADY), .bresp(M_AXI_BRESP),
		.bvalid(M_AXI_BVALID), .bready(M_AXI_BREADY)
	);

	// ------------------------------------------------------------
	// AXI slave, handshakes sampled mid-cycle
	// ------------------------------------------------------------
	always @(negedge M_AXI_ACLK) begin
		aw_hs = M_AXI_AWVALID && M_AXI_AWREADY;
		wl_hs = M_AXI_WVALID && M_AXI_WREADY && M_AXI_WLAST;
		b_hs = M_AXI_BVALID && M_AXI_BREADY;
	end

	always @(posedge M_AXI_ACLK) begin
		#1;
		if (!M_AXI_ARESETN) begin
			aw_cnt = 0;
			wl_cnt = 0;
			b_cnt = 0;
			M_AXI_AWREADY = 1'b0;
			M_AXI_WREADY = 1'b0;
			M_AXI_BVALID = 1'b0;
			M_AXI_BRESP = 2'b00;
		end else begin
			if (aw_hs)
				aw_cnt++;
			if (wl_hs)
				wl_cnt++;
			if (b_hs) begin
				b_cnt++;
				M_AXI_BVALID = 1'b0;
			end
			M_AXI_AWREADY = ($random(seed) & 3) != 0;
			M_AXI_WREADY = ($random(seed) & 3) != 0;
			// Respond only once address and last data are both in
			if (!M_AXI_BVALID && b_cnt < aw_cnt && b_cnt < wl_cnt && ($random(seed) & 1)) begin
				M_AXI_BVALID = 1'b1;
				M_AXI_BRESP = (b_cnt == td[td_err_burst]) ? 2'b10 : 2'b00;
			end
		end
	end

	// ------------------------------------------------------------
	// Stimulus helpers
	// ------------------------------------------------------------
	task automatic drive_pixel(input int word_idx, input int p);
		@(posedge M_AXI_ACLK);
		#1;
		pixel_valid = 1'b1;
		pixel = td[word_idx + p / 4][8 * (p % 4) +: 8];
		pixel_sof = (p == 0);
	endtask

	task automatic idle_pixels();
		@(posedge M_AXI_ACLK);
		#1;
		pixel_valid = 1'b0;
		pixel_sof = 1'b0;
	endtask

	task automatic send_frame(input int word_idx, input int count);
		for (int p = 0; p < count; p++)
			drive_pixel(word_idx, p);
		idle_pixels();
	endtask

	task automatic wait_frame_pulse();
		int n;
		n = 0;
		do begin
			@(negedge M_AXI_ACLK);
			n++;
		end while (!frame_pulse && n < wait_limit);
		if (!frame_pulse) begin
			$display("timeout waiting for the frame pulse");
			timeouts++;
		end
	endtask

	task automatic wait_burst_open(input int aw_before);
		int n;
		n = 0;
		while (!M_AXI_AWVALID && aw_cnt == aw_before && n < wait_limit) begin
			@(negedge M_AXI_ACLK);
			n++;
		end
		if (n == wait_limit) begin
			$display("timeout waiting for a burst to open");
			timeouts++;
		end
	endtask

	task automatic wait_reset_done();
		int n;
		n = 0;
		do begin
			@(negedge M_AXI_ACLK);
			n++;
		end while (resetting && n < wait_limit);
		if (resetting) begin
			$display("timeout waiting for the soft reset to finish");
			timeouts++;
		end
	endtask

	task automatic check_frame_memory(input logic [31:0] base, input int word_idx);
		for (int i = 0; i < frame_bursts * burst_len; i++)
			i_checker.check_word(base + 32'(4 * i), td[word_idx + i]);
	endtask

	initial begin
		int aw_before;
		$readmemh("dv/frame_testdata.hex", td);
		M_AXI_ACLK = 1'b0;
		M_AXI_ARESETN = 1'b0;
		soft_resetn = 1'b1;
		pixel_valid = 1'b0;
		pixel = '0;
		pixel_sof = 1'b0;
		M_AXI_AWREADY = 1'b0;
		M_AXI_WREADY = 1'b0;
		M_AXI_BVALID = 1'b0;
		M_AXI_BRESP = 2'b00;
		M_AXI_BID = '0;
		img_width = img_wbits'(td[td_width]);
		img_height = img_hbits'(td[td_height]);
		base_addr = td[td_base0];
		frame_bursts = td[td_width] * td[td_height] / (4 * burst_len);
		repeat (3) @(posedge M_AXI_ACLK);
		#1;
		M_AXI_ARESETN = 1'b1;

		// Frame 0, includes the SLVERR burst
		send_frame(td_frame0, frame_bursts * burst_len * 4);
		wait_frame_pulse();
		check_frame_memory(td[td_base0], td_frame0);

		// Frame 1, short soft reset pulse while its first burst is open
		@(posedge M_AXI_ACLK);
		#1;
		base_addr = td[td_base1];
		aw_before = aw_cnt;
		for (int p = 0; p < td[td_reset_px]; p++)
			drive_pixel(td_frame1, p);
		wait_burst_open(aw_before);
		@(posedge M_AXI_ACLK);
		#1;
		soft_resetn = 1'b0;
		pixel_valid = 1'b0;
		pixel_sof = 1'b0;
		// Released before the open burst can get its response
		@(posedge M_AXI_ACLK);
		#1;
		soft_resetn = 1'b1;
		wait_reset_done();

		// Frame 2 lands on the same base
		@(posedge M_AXI_ACLK);
		#1;
		send_frame(td_frame2, frame_bursts * burst_len * 4);
		wait_frame_pulse();
		check_frame_memory(td[td_base1], td_frame2);

		repeat (5) @(posedge M_AXI_ACLK);
		i_checker.final_checks(2);
		$display("mismatches %0d, other errors %0d, timeouts %0d",
			i_checker.mismatches, i_checker.failures, timeouts);
		if (i_checker.mismatches + i_checker.failures + timeouts == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: hw/aw_channel.sv
/* AXI write address channel, latches the burst address at start
   and holds AWVALID until the slave takes it */
module aw_channel #(
	parameter int addr_width = 32
) (
	input logic M_AXI_ACLK,
	input logic M_AXI_ARESETN,
	output logic [addr_width-1:0] M_AXI_AWADDR,
	output logic M_AXI_AWVALID,
	input logic M_AXI_AWREADY,
	burst_if.aw bus
);

	logic [addr_width-1:0] awaddr_q;
	logic awvalid_q;

	always_ff @(posedge M_AXI_ACLK) begin
		if (bus.start)
			awaddr_q <= bus.addr;
	end

	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN)
			awvalid_q <= 1'b0;
		else if (!awvalid_q && bus.start)
			awvalid_q <= 1'b1;
		else if (awvalid_q && M_AXI_AWREADY)
			awvalid_q <= 1'b0;
	end

	assign M_AXI_AWADDR = awaddr_q;
	assign M_AXI_AWVALID = awvalid_q;

	// Address accepted
	assign bus.aw_done = awvalid_q && M_AXI_AWREADY;

endmodule

// File: hw/beat_fifo.sv
/* Synchronous first-word-fall-through FIFO of tagged beats.
   Writes to a full FIFO are dropped and latch the overflow flag. */
module beat_fifo #(
	parameter int fifo_depth = 32
) (
	input logic M_AXI_ACLK,
	input logic M_AXI_ARESETN,
	input logic wr_en,
	input fb_pkg::tagged_beat_t wr_beat,
	input logic rd_en,
	output fb_pkg::tagged_beat_t rd_beat,
	output logic empty,
	output logic overflow
);

	import fb_pkg::*;

	localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;

	tagged_beat_t mem [fifo_depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [ptr_w:0] count;
	logic full;
	logic do_wr;
	logic do_rd;

	assign full = (count == (ptr_w + 1)'(fifo_depth));
	assign empty = (count == '0);
	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	// Head of queue is always visible
	assign rd_beat = mem[rd_ptr];

	always_ff @(posedge M_AXI_ACLK) begin
		if (do_wr)
			mem[wr_ptr] <= wr_beat;
	end

	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			overflow <= 1'b0;
		end else begin
			if (do_wr)
				wr_ptr <= (wr_ptr == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + (ptr_w + 1)'(do_wr) - (ptr_w + 1)'(do_rd);
			if (wr_en && full)
				overflow <= 1'b1;
		end
	end

	a_no_read_empty: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		rd_en |-> !empty);

endmodule

// File: hw/burst_if.sv
/* Burst handshake between the control block and the AW and W channel blocks */
interface burst_if #(
	parameter int addr_width = 32
) (
	input logic M_AXI_ACLK
);

	// Issued by control, one cycle
	logic start;
	logic [addr_width-1:0] addr;

	// Completion strobes from the channel blocks
	logic w_last_done;
	logic aw_done;

	modport ctrl (
		input M_AXI_ACLK,
		output start,
		output addr,
		input w_last_done,
		input aw_done
	);

	modport aw (input M_AXI_ACLK, input start, input addr, output aw_done);

	modport w (input M_AXI_ACLK, input start, output w_last_done);

endinterface

// File: hw/fb_pkg.sv
/* Shared types and fixed AXI field values for the frame writer.
   Imported by the packer, FIFO, control block and top level. */
package fb_pkg;

	localparam int pixel_width = 8;

	// One data word, seen as raw bus data or as four pixel lanes
	typedef union packed {
		logic [31:0] word;
		logic [3:0][pixel_width-1:0] lane;
	} beat_t;

	// FIFO entry, the beat plus its start-of-frame tag
	typedef struct packed {
		logic sof;
		beat_t beat;
	} tagged_beat_t;

	// ------------------------------------------------------------
	// Fixed AXI write address fields
	// ------------------------------------------------------------
	localparam logic [1:0] awburst_incr = 2'b01;
	// Modifiable, response comes from the memory side
	localparam logic [3:0] awcache_val = 4'b0010;
	localparam int bresp_slverr_bit = 1;

	// AXI size code for a full-width beat
	function automatic logic [2:0] awsize_for(input int data_width);
		int bytes;
		bytes = data_width / 8;
		return 3'($clog2(bytes));
	endfunction

endpackage

// File: hw/frame_writer_ctrl.sv
/* Burst scheduler for the frame writer. Chooses burst addresses, tracks the
   frame position, handles soft reset and raises the end-of-frame pulse. */
module frame_writer_ctrl #(
	parameter int burst_len = 16,
	parameter int addr_width = 32,
	parameter int data_width = 32,
	parameter int img_wbits = 12,
	parameter int img_hbits = 12
) (
	input logic M_AXI_ACLK,
	input logic M_AXI_ARESETN,
	input logic soft_resetn,
	output logic resetting,
	input logic [img_wbits-1:0] img_width,
	input logic [img_hbits-1:0] img_height,
	input logic [addr_width-1:0] base_addr,
	input logic fifo_empty,
	input logic head_sof,
	input logic wnext,
	input logic M_AXI_BVALID,
	input logic [1:0] M_AXI_BRESP,
	output logic frame_pulse,
	output logic bresp_error,
	burst_if.ctrl bus
);

	import fb_pkg::*;

	localparam int burst_bytes = burst_len * data_width / 8;
	localparam int adata_pixels = data_width / pixel_width;

	logic soft_resetn_q;
	logic soft_fall;
	logic soft_busy;
	logic start_q;
	logic start_cond;
	logic burst_active;
	logic addr_sent;
	logic data_sent;
	logic burst_done;
	logic frame_restart;
	logic [addr_width-1:0] addr_q;
	logic [img_wbits-1:0] col_idx;
	logic [img_hbits-1:0] row_idx;

	// ------------------------------------------------------------
	// Soft reset
	// ------------------------------------------------------------
	assign soft_fall = !soft_resetn && soft_resetn_q;
	assign resetting = soft_busy || !soft_resetn;

	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			soft_resetn_q <= 1'b0;
			soft_busy <= 1'b0;
		end else begin
			soft_resetn_q <= soft_resetn;
			// Open burst must finish before we report idle
			if (burst_done)
				soft_busy <= 1'b0;
			else if (soft_fall && (start_q || burst_active))
				soft_busy <= 1'b1;
		end
	end

	// ------------------------------------------------------------
	// Burst scheduling
	// ------------------------------------------------------------
	assign start_cond = !start_q && !burst_active && !fifo_empty && soft_resetn;
	assign frame_restart = head_sof || (col_idx == '0 && row_idx == '0);
	// Response only counts once address and last data are through
	assign burst_done = M_AXI_BVALID && burst_active && addr_sent && data_sent;

	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			start_q <= 1'b0;
			burst_active <= 1'b0;
			addr_sent <= 1'b0;
			data_sent <= 1'b0;
		end else begin
			start_q <= start_cond;
			if (start_q)
				burst_active <= 1'b1;
			else if (burst_done)
				burst_active <= 1'b0;
			if (start_q) begin
				addr_sent <= 1'b0;
				data_sent <= 1'b0;
			end else begin
				if (bus.aw_done)
					addr_sent <= 1'b1;
				if (bus.w_last_done)
					data_sent <= 1'b1;
			end
		end
	end

	// Address is ready by the time start is seen
	always_ff @(posedge M_AXI_ACLK) begin
		if (start_cond)
			addr_q <= frame_restart ? base_addr : addr_q + addr_width'(burst_bytes);
	end

	assign bus.start = start_q;
	assign bus.addr = addr_q;

	// Column and row count down, zero means frame done
	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN || resetting) begin
			col_idx <= '0;
			row_idx <= '0;
		end else if (start_cond && frame_restart) begin
			col_idx <= img_width - img_wbits'(adata_pixels);
			row_idx <= img_height - 1'b1;
		end else if (wnext) begin
			if (col_idx != '0) begin
				col_idx <= col_idx - img_wbits'(adata_pixels);
			end else if (row_idx != '0) begin
				col_idx <= img_width - img_wbits'(adata_pixels);
				row_idx <= row_idx - 1'b1;
			end
		end
	end

	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			frame_pulse <= 1'b0;
			bresp_error <= 1'b0;
		end else begin
			frame_pulse <= burst_done && !resetting && col_idx == '0 && row_idx == '0;
			if (burst_done && M_AXI_BRESP[bresp_slverr_bit])
				bresp_error <= 1'b1;
		end
	end

	a_one_burst: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		burst_active |-> !start_q);

endmodule

// File: hw/frame_writer_top.sv
/* Frame writer top level. Takes an 8-bit pixel stream and writes frames
   to memory through the AXI4 write channels. */
module frame_writer_top #(
	parameter int burst_len = 16,
	parameter int addr_width = 32,
	parameter int data_width = 32,
	parameter int img_wbits = 12,
	parameter int img_hbits = 12,
	parameter int fifo_depth = 32
) (
	input logic M_AXI_ACLK,
	input logic M_AXI_ARESETN,
	input logic soft_resetn,
	output logic resetting,
	input logic [img_wbits-1:0] img_width,
	input logic [img_hbits-1:0] img_height,
	input logic [addr_width-1:0] base_addr,
	input logic pixel_valid,
	input logic [fb_pkg::pixel_width-1:0] pixel,
	input logic pixel_sof,
	output logic frame_pulse,
	output logic bresp_error,
	output logic overflow,
	output logic [0:0] M_AXI_AWID,
	output logic [addr_width-1:0] M_AXI_AWADDR,
	output logic [7:0] M_AXI_AWLEN,
	output logic [2:0] M_AXI_AWSIZE,
	output logic [1:0] M_AXI_AWBURST,
	output logic M_AXI_AWLOCK,
	output logic [3:0] M_AXI_AWCACHE,
	output logic [2:0] M_AXI_AWPROT,
	output logic [3:0] M_AXI_AWQOS,
	output logic M_AXI_AWVALID,
	input logic M_AXI_AWREADY,
	output logic [data_width-1:0] M_AXI_WDATA,
	output logic [data_width/8-1:0] M_AXI_WSTRB,
	output logic M_AXI_WLAST,
	output logic M_AXI_WVALID,
	input logic M_AXI_WREADY,
	input logic [0:0] M_AXI_BID,
	input logic [1:0] M_AXI_BRESP,
	input logic M_AXI_BVALID,
	output logic M_AXI_BREADY
);

	import fb_pkg::*;

	logic wr_en;
	tagged_beat_t wr_beat;
	tagged_beat_t rd_beat;
	logic rd_en;
	logic fifo_empty;
	logic wnext;

	burst_if #(.addr_width(addr_width)) i_burst_if (.M_AXI_ACLK(M_AXI_ACLK));

	pixel_packer i_packer (
		.M_AXI_ACLK(M_AXI_ACLK),
		.M_AXI_ARESETN(M_AXI_ARESETN),
		.pixel_valid(pixel_valid),
		.pixel(pixel),
		.pixel_sof(pixel_sof),
		.wr_en(wr_en),
		.wr_beat(wr_beat)
	);

	beat_fifo #(.fifo_depth(fifo_depth)) i_fifo (
		.M_AXI_ACLK(M_AXI_ACLK),
		.M_AXI_ARESETN(M_AXI_ARESETN),
		.wr_en(wr_en),
		.wr_beat(wr_beat),
		.rd_en(rd_en),
		.rd_beat(rd_beat),
		.empty(fifo_empty),
		.overflow(overflow)
	);

	frame_writer_ctrl #(
		.burst_len(burst_len),
		.addr_width(addr_width),
		.data_width(data_width),
		.img_wbits(img_wbits),
		.img_hbits(img_hbits)
	) i_ctrl (
		.M_AXI_ACLK(M_AXI_ACLK),
		.M_AXI_ARESETN(M_AXI_ARESETN),
		.soft_resetn(soft_resetn),
		.resetting(resetting),
		.img_width(img_width),
		.img_height(img_height),
		.base_addr(base_addr),
		.fifo_empty(fifo_empty),
		.head_sof(rd_beat.sof),
		.wnext(wnext),
		.M_AXI_BVALID(M_AXI_BVALID),
		.M_AXI_BRESP(M_AXI_BRESP),
		.frame_pulse(frame_pulse),
		.bresp_error(bresp_error),
		.bus(i_burst_if.ctrl)
	);

	aw_channel #(.addr_width(addr_width)) i_aw (
		.M_AXI_ACLK(M_AXI_ACLK),
		.M_AXI_ARESETN(M_AXI_ARESETN),
		.M_AXI_AWADDR(M_AXI_AWADDR),
		.M_AXI_AWVALID(M_AXI_AWVALID),
		.M_AXI_AWREADY(M_AXI_AWREADY),
		.bus(i_burst_if.aw)
	);

	w_channel #(.burst_len(burst_len), .data_width(data_width)) i_w (
		.M_AXI_ACLK(M_AXI_ACLK),
		.M_AXI_ARESETN(M_AXI_ARESETN),
		.fifo_empty(fifo_empty),
		.rd_beat(rd_beat),
		.resetting(resetting),
		.rd_en(rd_en),
		.wnext(wnext),
		.M_AXI_WDATA(M_AXI_WDATA),
		.M_AXI_WLAST(M_AXI_WLAST),
		.M_AXI_WVALID(M_AXI_WVALID),
		.M_AXI_WREADY(M_AXI_WREADY),
		.bus(i_burst_if.w)
	);

	// ------------------------------------------------------------
	// Constant AXI fields
	// ------------------------------------------------------------
	assign M_AXI_AWID = '0;
	assign M_AXI_AWLEN = 8'(burst_len - 1);
	assign M_AXI_AWSIZE = awsize_for(data_width);
	assign M_AXI_AWBURST = awburst_incr;
	assign M_AXI_AWLOCK = 1'b0;
	assign M_AXI_AWCACHE = awcache_val;
	assign M_AXI_AWPROT = 3'h0;
	assign M_AXI_AWQOS = 4'h0;
	// Full-width aligned beats only
	assign M_AXI_WSTRB = '1;
	assign M_AXI_BREADY = M_AXI_BVALID;

	// Single ID, every response must carry it back
	a_bid_match: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		M_AXI_BVALID |-> (M_AXI_BID == M_AXI_AWID));

endmodule

// File: hw/pixel_packer.sv
/* Packs four 8-bit pixel strobes into one tagged beat and writes it to the FIFO.
   A strobe with pixel_sof restarts at lane 0 and tags that beat. */
module pixel_packer (
	input logic M_AXI_ACLK,
	input logic M_AXI_ARESETN,
	input logic pixel_valid,
	input logic [fb_pkg::pixel_width-1:0] pixel,
	input logic pixel_sof,
	output logic wr_en,
	output fb_pkg::tagged_beat_t wr_beat
);

	import fb_pkg::*;

	logic [1:0] lane_cnt;
	logic [1:0] lane_idx;
	beat_t beat_q;
	logic sof_q;

	// Start of frame forces lane 0
	assign lane_idx = pixel_sof ? 2'd0 : lane_cnt;

	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			lane_cnt <= 2'd0;
			wr_en <= 1'b0;
		end else begin
			wr_en <= pixel_valid && (lane_idx == 2'd3);
			if (pixel_valid)
				lane_cnt <= lane_idx + 2'd1;
		end
	end

	// Lane fill and sof capture
	always_ff @(posedge M_AXI_ACLK) begin
		if (pixel_valid) begin
			beat_q.lane[lane_idx] <= pixel;
			if (lane_idx == 2'd0)
				sof_q <= pixel_sof;
		end
	end

	assign wr_beat.beat = beat_q;
	assign wr_beat.sof = sof_q;

	// A beat needs at least four strobes
	a_beat_spacing: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		wr_en |=> !wr_en [*3]);

endmodule

// File: hw/w_channel.sv
/* AXI write data channel. Refills a one-beat data register from the FIFO,
   counts the burst down to WLAST and flushes the burst on soft reset. */
module w_channel #(
	parameter int burst_len = 16,
	parameter int data_width = 32
) (
	input logic M_AXI_ACLK,
	input logic M_AXI_ARESETN,
	input logic fifo_empty,
	input fb_pkg::tagged_beat_t rd_beat,
	input logic resetting,
	output logic rd_en,
	output logic wnext,
	output logic [data_width-1:0] M_AXI_WDATA,
	output logic M_AXI_WLAST,
	output logic M_AXI_WVALID,
	input logic M_AXI_WREADY,
	burst_if.w bus
);

	localparam int cnt_w = $clog2(burst_len + 1);

	logic need_data;
	logic dvalid;
	logic [cnt_w-1:0] rd_left;
	logic [cnt_w-1:0] write_index;
	logic [data_width-1:0] wdata_q;
	logic wlast_q;
	logic load;

	// During soft reset the FIFO is drained and nothing is loaded
	assign rd_en = !fifo_empty && (resetting || (rd_left != '0 && (!dvalid || wnext)));
	assign load = rd_en && !resetting;
	assign wnext = M_AXI_WVALID && M_AXI_WREADY;

	always_ff @(posedge M_AXI_ACLK) begin
		if (load)
			wdata_q <= rd_beat.beat.word;
	end

	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			need_data <= 1'b0;
			dvalid <= 1'b0;
			rd_left <= '0;
			write_index <= '0;
			wlast_q <= 1'b0;
		end else begin
			if (!need_data && bus.start)
				need_data <= 1'b1;
			else if (wnext && wlast_q)
				need_data <= 1'b0;
			if (load)
				dvalid <= 1'b1;
			else if (wnext)
				dvalid <= 1'b0;
			// Reads left in this burst
			if (bus.start)
				rd_left <= cnt_w'(burst_len);
			else if (load)
				rd_left <= rd_left - 1'b1;
			if (bus.start) begin
				write_index <= cnt_w'(burst_len - 1);
				wlast_q <= (burst_len == 1);
			end else if (wnext) begin
				if (write_index != '0)
					write_index <= write_index - 1'b1;
				wlast_q <= (write_index == cnt_w'(1));
			end
		end
	end

	assign M_AXI_WDATA = wdata_q;
	assign M_AXI_WLAST = wlast_q;
	assign M_AXI_WVALID = need_data && (dvalid || resetting);
	assign bus.w_last_done = wnext && wlast_q;

	a_wlast_final: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		wnext |-> (M_AXI_WLAST == (write_index == '0)));

endmodule

// File: src.f
hw/fb_pkg.sv
hw/burst_if.sv
hw/pixel_packer.sv
hw/beat_fifo.sv
hw/frame_writer_ctrl.sv
hw/aw_channel.sv
hw/w_channel.sv
hw/frame_writer_top.sv
dv/frame_checker.sv
dv/tb_frame_writer.sv
